/* id_map_pkg.sv */
package id_map_pkg;

  // every id in the subsystem is this wide, fids and rids alike
  localparam int ID_W = 4;
  localparam int MAX_ID = 2 ** ID_W; // upper bound for NUMID

  typedef logic [ID_W-1:0] id_t; // foreign or local id
  typedef logic [ID_W:0]   cnt_t; // free count, 0 .. MAX_ID

  // one release port, request side
  typedef struct packed {
    logic en;
    id_t  rid;
  } rel_req_t;

  // one release port, answer side
  typedef struct packed {
    logic vld; // entry was mapped and is now released
    id_t  fid; // fid that was stored under the rid
  } rel_rsp_t;

endpackage

/* id_free_pool.sv */
module id_free_pool #(
  parameter int NUMID = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             alloc,
  output logic             alloc_ok,
  output id_map_pkg::id_t  alloc_rid,
  input  logic             free_0,
  input  id_map_pkg::id_t  free_rid_0,
  input  logic             free_1,
  input  id_map_pkg::id_t  free_rid_1,
  output id_map_pkg::cnt_t free_cnt
);

  logic [NUMID-1:0] busy_q;
  logic [NUMID-1:0] busy_d;
  logic             have_free;
  id_map_pkg::id_t  low_rid;
  id_map_pkg::cnt_t cnt_q;
  id_map_pkg::cnt_t cnt_d;

  // scan from the top so the lowest free rid is the last one written
  always_comb begin
    have_free = 1'b0;
    low_rid   = '0;
    for (int i = NUMID - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        have_free = 1'b1;
        low_rid   = id_map_pkg::id_t'(i);
      end
    end
  end

  assign alloc_ok  = alloc && have_free; // low means retry later
  assign alloc_rid = low_rid;
  assign free_cnt  = cnt_q;

  // grant works on registered busy bits, so a rid freed now is
  // only handed out again from the next cycle on
  always_comb begin
    busy_d = busy_q;
    if (free_0) begin
      busy_d[free_rid_0] = 1'b0;
    end
    if (free_1) begin
      busy_d[free_rid_1] = 1'b0;
    end
    if (alloc_ok) begin
      busy_d[low_rid] = 1'b1;
    end
  end

  always_comb begin
    cnt_d = cnt_q
          + id_map_pkg::cnt_t'(free_0)
          + id_map_pkg::cnt_t'(free_1)
          - id_map_pkg::cnt_t'(alloc_ok);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
      cnt_q  <= id_map_pkg::cnt_t'(NUMID); // everything free
    end else begin
      busy_q <= busy_d;
      cnt_q  <= cnt_d;
    end
  end

  a_cnt_max: assert property (
    @(posedge clk) disable iff (rst)
    cnt_q <= NUMID
  );

  // the counter is kept separately from the bitmap, so it may drift
  a_cnt_bits: assert property (
    @(posedge clk) disable iff (rst)
    cnt_q == id_map_pkg::cnt_t'($countones(~busy_q))
  );

endmodule

/* id_map_table.sv */
module id_map_table #(
  parameter int NUMID = 16
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr,
  input  id_map_pkg::id_t      wr_rid,
  input  id_map_pkg::id_t      wr_fid,
  input  id_map_pkg::id_t      lkp_rid,
  output logic                 lkp_vld,
  output id_map_pkg::id_t      lkp_fid,
  input  id_map_pkg::rel_req_t rel_0,
  output id_map_pkg::rel_rsp_t rel_rsp_0,
  input  id_map_pkg::rel_req_t rel_1,
  output id_map_pkg::rel_rsp_t rel_rsp_1
);

  id_map_pkg::id_t  fid_mem [NUMID];
  logic [NUMID-1:0] vld_q;

  // a release port only confirms enabled requests on mapped entries
  function automatic id_map_pkg::rel_rsp_t rel_read(id_map_pkg::rel_req_t req);
    id_map_pkg::rel_rsp_t rsp;
    rsp.vld = req.en && vld_q[req.rid];
    rsp.fid = fid_mem[req.rid];
    return rsp;
  endfunction

  assign lkp_vld = vld_q[lkp_rid]; // old mapping even if released now
  assign lkp_fid = fid_mem[lkp_rid];

  always_comb begin
    rel_rsp_0 = rel_read(rel_0);
    rel_rsp_1 = rel_read(rel_1);
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      fid_mem[wr_rid] <= wr_fid;
    end
  end

  // write and release never hit the same rid, pool grants free rids only
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= '0;
    end else begin
      if (rel_rsp_0.vld) begin
        vld_q[rel_0.rid] <= 1'b0;
      end
      if (rel_rsp_1.vld) begin
        vld_q[rel_1.rid] <= 1'b0;
      end
      if (wr) begin
        vld_q[wr_rid] <= 1'b1;
      end
    end
  end

  // pool and table must agree on which rids are taken
  a_wr_free: assert property (
    @(posedge clk) disable iff (rst)
    wr |-> !vld_q[wr_rid]
  );

endmodule

/* id_mapper.sv */
module id_mapper #(
  parameter int NUMID = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             fmap,
  input  id_map_pkg::id_t  fmap_fid,
  output logic             fmap_vld,
  output id_map_pkg::id_t  fmap_rid,
  input  logic             rlkp,
  input  id_map_pkg::id_t  rlkp_rid,
  output logic             rlkp_vld,
  output id_map_pkg::id_t  rlkp_fid,
  input  logic             rmap_0,
  input  id_map_pkg::id_t  rmap_rid_0,
  output logic             rmap_vld_0,
  output id_map_pkg::id_t  rmap_fid_0,
  input  logic             rmap_1,
  input  id_map_pkg::id_t  rmap_rid_1,
  output logic             rmap_vld_1,
  output id_map_pkg::id_t  rmap_fid_1,
  output id_map_pkg::cnt_t free_cnt
);

  logic                 same_rid;
  logic                 lkp_vld;
  id_map_pkg::rel_req_t rel_req_0;
  id_map_pkg::rel_req_t rel_req_1;
  id_map_pkg::rel_rsp_t rel_rsp_0;
  id_map_pkg::rel_rsp_t rel_rsp_1;

  // port 0 wins when both ports release the same rid
  assign same_rid  = rmap_0 && (rmap_rid_0 == rmap_rid_1);
  assign rel_req_0 = '{en: rmap_0, rid: rmap_rid_0};
  assign rel_req_1 = '{en: rmap_1 && !same_rid, rid: rmap_rid_1};

  id_free_pool #(
    .NUMID(NUMID)
  ) u_pool (
    .clk       (clk),
    .rst       (rst),
    .alloc     (fmap),
    .alloc_ok  (fmap_vld),
    .alloc_rid (fmap_rid),
    .free_0    (rel_rsp_0.vld), // only confirmed releases reach the pool
    .free_rid_0(rmap_rid_0),
    .free_1    (rel_rsp_1.vld),
    .free_rid_1(rmap_rid_1),
    .free_cnt  (free_cnt)
  );

  id_map_table #(
    .NUMID(NUMID)
  ) u_table (
    .clk      (clk),
    .rst      (rst),
    .wr       (fmap_vld), // granted rid takes the requester's fid
    .wr_rid   (fmap_rid),
    .wr_fid   (fmap_fid),
    .lkp_rid  (rlkp_rid),
    .lkp_vld  (lkp_vld),
    .lkp_fid  (rlkp_fid),
    .rel_0    (rel_req_0),
    .rel_rsp_0(rel_rsp_0),
    .rel_1    (rel_req_1),
    .rel_rsp_1(rel_rsp_1)
  );

  assign rlkp_vld   = rlkp && lkp_vld;
  assign rmap_vld_0 = rel_rsp_0.vld;
  assign rmap_fid_0 = rel_rsp_0.fid;
  assign rmap_vld_1 = rel_rsp_1.vld;
  assign rmap_fid_1 = rel_rsp_1.fid;

  // a rid being released this cycle must not be granted this cycle
  a_no_reuse: assert property (
    @(posedge clk) disable iff (rst)
    fmap_vld |-> !(rmap_vld_0 && (fmap_rid == rmap_rid_0))
              && !(rmap_vld_1 && (fmap_rid == rmap_rid_1))
  );

endmodule

/* id_mapper_sva.sv */
module id_mapper_sva #(
  parameter int NUMID = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             fmap,
  input  id_map_pkg::id_t  fmap_fid,
  output logic             fmap_vld,
  output id_map_pkg::id_t  fmap_rid,
  input  logic             rlkp,
  input  id_map_pkg::id_t  rlkp_rid,
  output logic             rlkp_vld,
  output id_map_pkg::id_t  rlkp_fid,
  input  logic             rmap_0,
  input  id_map_pkg::id_t  rmap_rid_0,
  output logic             rmap_vld_0,
  output id_map_pkg::id_t  rmap_fid_0,
  input  logic             rmap_1,
  input  id_map_pkg::id_t  rmap_rid_1,
  output logic             rmap_vld_1,
  output id_map_pkg::id_t  rmap_fid_1,
  output id_map_pkg::cnt_t free_cnt
);

  if (NUMID < 2 || NUMID > id_map_pkg::MAX_ID) begin : g_bad_numid
    $error("NUMID %0d outside 2..%0d", NUMID, id_map_pkg::MAX_ID);
  end

  id_mapper #(
    .NUMID(NUMID)
  ) core (
    .*
  );

  id_map_pkg::id_t  map_q [NUMID]; // shadow fid per rid
  logic [NUMID-1:0] map_vld_q;
  logic             rel1_alone;

  always_ff @(posedge clk) begin
    if (fmap && fmap_vld) begin
      map_q[fmap_rid] <= fmap_fid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      map_vld_q <= '0;
    end else begin
      if (fmap && fmap_vld) begin
        map_vld_q[fmap_rid] <= 1'b1;
      end
      if (rmap_0 && rmap_vld_0) begin
        map_vld_q[rmap_rid_0] <= 1'b0;
      end
      if (rmap_1 && rmap_vld_1) begin
        map_vld_q[rmap_rid_1] <= 1'b0;
      end
    end
  end

  // port 1 loses to port 0 on the same rid
  assign rel1_alone = !(rmap_0 && (rmap_rid_0 == rmap_rid_1));

  a_rmap0_match: assert property (
    @(posedge clk) disable iff (rst)
    (rmap_0 && map_vld_q[rmap_rid_0])
      |-> rmap_vld_0 && (rmap_fid_0 == map_q[rmap_rid_0])
  );

  a_rmap1_match: assert property (
    @(posedge clk) disable iff (rst)
    (rmap_1 && rel1_alone && map_vld_q[rmap_rid_1])
      |-> rmap_vld_1 && (rmap_fid_1 == map_q[rmap_rid_1])
  );

  a_rlkp_match: assert property (
    @(posedge clk) disable iff (rst)
    (rlkp && map_vld_q[rlkp_rid])
      |-> rlkp_vld && (rlkp_fid == map_q[rlkp_rid])
  );

  a_fmap_free: assert property (
    @(posedge clk) disable iff (rst)
    fmap_vld |-> (free_cnt != 0) && !map_vld_q[fmap_rid]
  );

  a_cnt_range: assert property (
    @(posedge clk) disable iff (rst)
    free_cnt <= NUMID
  );

  a_id_range: assert property (
    @(posedge clk) disable iff (rst)
    (fmap_fid < NUMID) && (rlkp_rid < NUMID)
      && (rmap_rid_0 < NUMID) && (rmap_rid_1 < NUMID)
  ) else $error("id out of range fmap_fid=%0h rlkp_rid=%0h rmap_rid_0=%0h rmap_rid_1=%0h",
                fmap_fid, rlkp_rid, rmap_rid_0, rmap_rid_1);

endmodule

/* tb_id_mapper_checks.svh */
`ifndef TB_ID_MAPPER_CHECKS_SVH
`define TB_ID_MAPPER_CHECKS_SVH

// error counters, one per kind of result
int id_errs  = 0;
int cnt_errs = 0;
int bit_errs = 0;

task automatic check_id(
  input string           test,
  input string           sig,
  input id_map_pkg::id_t exp,
  input id_map_pkg::id_t act
);
  if (act !== exp) begin
    id_errs++;
    $display("** Error [%s] %s: expected %0h, actual %0h at %0t", test, sig, exp, act, $time);
  end
endtask

task automatic check_cnt(
  input string            test,
  input string            sig,
  input id_map_pkg::cnt_t exp,
  input id_map_pkg::cnt_t act
);
  if (act !== exp) begin
    cnt_errs++;
    $display("** Error [%s] %s: expected %0d, actual %0d at %0t", test, sig, exp, act, $time);
  end
endtask

task automatic check_bit(
  input string test,
  input string sig,
  input logic  exp,
  input logic  act
);
  if (act !== exp) begin
    bit_errs++;
    $display("** Error [%s] %s: expected %b, actual %b at %0t", test, sig, exp, act, $time);
  end
endtask

function automatic int total_errs();
  return id_errs + cnt_errs + bit_errs;
endfunction

`endif

/* tb_id_mapper.sv */
module tb_id_mapper;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUMID          = 16;
  localparam int CLK_PERIOD     = 100;
  localparam int TEST_CYCLES    = 400; // upper estimate over all tests
  localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

  logic             clk = 1'b0;
  logic             rst;
  logic             fmap;
  id_map_pkg::id_t  fmap_fid;
  logic             fmap_vld;
  id_map_pkg::id_t  fmap_rid;
  logic             rlkp;
  id_map_pkg::id_t  rlkp_rid;
  logic             rlkp_vld;
  id_map_pkg::id_t  rlkp_fid;
  logic             rmap_0;
  id_map_pkg::id_t  rmap_rid_0;
  logic             rmap_vld_0;
  id_map_pkg::id_t  rmap_fid_0;
  logic             rmap_1;
  id_map_pkg::id_t  rmap_rid_1;
  logic             rmap_vld_1;
  id_map_pkg::id_t  rmap_fid_1;
  id_map_pkg::cnt_t free_cnt;

  // reference model state
  id_map_pkg::id_t      model_fid [NUMID];
  logic [NUMID-1:0]     model_busy;
  id_map_pkg::cnt_t     model_free;
  logic                 exp_fmap_vld;
  id_map_pkg::id_t      exp_fmap_rid;
  logic                 exp_rlkp_vld;
  id_map_pkg::rel_rsp_t exp_rel_0;
  id_map_pkg::rel_rsp_t exp_rel_1;
  int                   cycle_cnt = 0;

  `include "tb_id_mapper_checks.svh"

  id_mapper_sva #(
    .NUMID(NUMID)
  ) i_dut (
    .*
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic id_map_pkg::id_t rand_id();
    return id_map_pkg::id_t'($urandom_range(NUMID - 1));
  endfunction

  // expected answers from model state and the inputs now applied
  function automatic void predict();
    exp_fmap_vld = 1'b0;
    exp_fmap_rid = '0;
    for (int i = 0; i < NUMID; i++) begin
      if (fmap && !exp_fmap_vld && !model_busy[i]) begin
        exp_fmap_vld = 1'b1; // lowest free rid wins
        exp_fmap_rid = id_map_pkg::id_t'(i);
      end
    end
    exp_rlkp_vld  = rlkp && model_busy[rlkp_rid];
    exp_rel_0.vld = rmap_0 && model_busy[rmap_rid_0];
    exp_rel_0.fid = model_fid[rmap_rid_0];
    exp_rel_1.vld = rmap_1 && model_busy[rmap_rid_1] && !(rmap_0 && rmap_rid_0 == rmap_rid_1);
    exp_rel_1.fid = model_fid[rmap_rid_1];
  endfunction

  task automatic cycle(input string name, input logic f, input id_map_pkg::id_t ffid,
                       input logic l, input id_map_pkg::id_t lrid,
                       input logic r0, input id_map_pkg::id_t rr0,
                       input logic r1, input id_map_pkg::id_t rr1);
    @(negedge clk);
    fmap       = f;
    fmap_fid   = ffid;
    rlkp       = l;
    rlkp_rid   = lrid;
    rmap_0     = r0;
    rmap_rid_0 = rr0;
    rmap_1     = r1;
    rmap_rid_1 = rr1;
    #(CLK_PERIOD / 4); // answers are settled well before the rising edge
    predict();
    check_bit(name, "fmap_vld", exp_fmap_vld, fmap_vld);
    if (exp_fmap_vld) check_id(name, "fmap_rid", exp_fmap_rid, fmap_rid);
    check_bit(name, "rlkp_vld", exp_rlkp_vld, rlkp_vld);
    if (exp_rlkp_vld) check_id(name, "rlkp_fid", model_fid[rlkp_rid], rlkp_fid);
    check_bit(name, "rmap_vld_0", exp_rel_0.vld, rmap_vld_0);
    if (exp_rel_0.vld) check_id(name, "rmap_fid_0", exp_rel_0.fid, rmap_fid_0);
    check_bit(name, "rmap_vld_1", exp_rel_1.vld, rmap_vld_1);
    if (exp_rel_1.vld) check_id(name, "rmap_fid_1", exp_rel_1.fid, rmap_fid_1);
    check_cnt(name, "free_cnt", model_free, free_cnt);
  endtask

  // model takes this cycle's updates, then the DUT sees the edge
  task automatic advance();
    if (exp_rel_0.vld) model_busy[rmap_rid_0] = 1'b0;
    if (exp_rel_1.vld) model_busy[rmap_rid_1] = 1'b0;
    if (exp_fmap_vld) begin
      model_busy[exp_fmap_rid] = 1'b1;
      model_fid[exp_fmap_rid]  = fmap_fid;
    end
    model_free = model_free + id_map_pkg::cnt_t'(exp_rel_0.vld)
               + id_map_pkg::cnt_t'(exp_rel_1.vld) - id_map_pkg::cnt_t'(exp_fmap_vld);
    @(posedge clk);
  endtask

  task automatic test_alloc_order();
    string name = "alloc_order";
    check_cnt(name, "free_cnt", id_map_pkg::cnt_t'(NUMID), free_cnt);
    for (int i = 0; i < NUMID; i++) begin
      cycle(name, 1'b1, rand_id(), 1'b0, '0, 1'b0, '0, 1'b0, '0);
      check_id(name, "fmap_rid", id_map_pkg::id_t'(i), fmap_rid);
      check_cnt(name, "free_cnt", id_map_pkg::cnt_t'(NUMID - i), free_cnt);
      advance();
    end
  endtask

  task automatic test_full_pool();
    string name = "full_pool";
    cycle(name, 1'b1, 4'h3, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    check_bit(name, "fmap_vld", 1'b0, fmap_vld); // no free rid left
    check_cnt(name, "free_cnt", '0, free_cnt);
    advance();
    cycle(name, 1'b0, '0, 1'b0, '0, 1'b1, 4'd5, 1'b0, '0);
    advance();
    cycle(name, 1'b1, 4'ha, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    check_id(name, "fmap_rid", 4'd5, fmap_rid);
    advance();
  endtask

  task automatic test_lookup();
    string name = "lookup";
    cycle(name, 1'b0, '0, 1'b1, 4'd3, 1'b0, '0, 1'b0, '0);
    check_bit(name, "rlkp_vld", 1'b1, rlkp_vld);
    advance();
    cycle(name, 1'b0, '0, 1'b1, 4'd3, 1'b1, 4'd3, 1'b0, '0);
    check_bit(name, "rlkp_vld", 1'b1, rlkp_vld); // old mapping during release
    advance();
    cycle(name, 1'b0, '0, 1'b1, 4'd3, 1'b0, '0, 1'b0, '0);
    check_bit(name, "rlkp_vld", 1'b0, rlkp_vld);
    advance();
  endtask

  task automatic test_release_ports();
    string            name = "release_ports";
    id_map_pkg::cnt_t cnt_before;
    cycle(name, 1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b1, 4'd7);
    check_bit(name, "rmap_vld_1", 1'b1, rmap_vld_1);
    cnt_before = model_free;
    advance();
    cycle(name, 1'b0, '0, 1'b0, '0, 1'b1, 4'd7, 1'b0, '0); // rid 7 is unmapped now
    check_cnt(name, "free_cnt", cnt_before + 1'b1, free_cnt);
    check_bit(name, "rmap_vld_0", 1'b0, rmap_vld_0);
    advance();
    cycle(name, 1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    check_cnt(name, "free_cnt", cnt_before + 1'b1, free_cnt);
    advance();
  endtask

  task automatic test_dual_release();
    string name = "dual_release";
    cycle(name, 1'b0, '0, 1'b0, '0, 1'b1, 4'd9, 1'b1, 4'd11);
    check_bit(name, "rmap_vld_0", 1'b1, rmap_vld_0);
    check_bit(name, "rmap_vld_1", 1'b1, rmap_vld_1);
    advance();
    cycle(name, 1'b0, '0, 1'b0, '0, 1'b1, 4'd12, 1'b1, 4'd12);
    check_bit(name, "rmap_vld_1", 1'b0, rmap_vld_1); // port 0 wins
    advance();
    // rids 0 and 1 sit below every free rid, so a same-cycle reuse would show
    cycle(name, 1'b1, 4'h6, 1'b0, '0, 1'b1, 4'd0, 1'b1, 4'd1);
    check_bit(name, "fmap_vld", 1'b1, fmap_vld);
    check_id(name, "fmap_rid", 4'd3, fmap_rid); // lowest rid free before the edge
    advance();
  endtask

  task automatic test_random();
    string name = "random";
    for (int i = 0; i < 200; i++) begin
      cycle(name, 1'($urandom_range(1)), rand_id(), 1'($urandom_range(1)), rand_id(),
            1'($urandom_range(1)), rand_id(), 1'($urandom_range(1)), rand_id());
      advance();
    end
  endtask

  initial begin
    void'($urandom(32'h81d5f3ab));
    rst        = 1'b1;
    fmap       = 1'b0;
    fmap_fid   = '0;
    rlkp       = 1'b0;
    rlkp_rid   = '0;
    rmap_0     = 1'b0;
    rmap_rid_0 = '0;
    rmap_1     = 1'b0;
    rmap_rid_1 = '0;
    model_busy = '0;
    model_free = id_map_pkg::cnt_t'(NUMID);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_alloc_order();
    test_full_pool();
    test_lookup();
    test_release_ports();
    test_dual_release();
    test_random();
    $display("errors: id %0d, cnt %0d, bit %0d", id_errs, cnt_errs, bit_errs);
    if (total_errs() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+.
id_map_pkg.sv
id_free_pool.sv
id_map_table.sv
id_mapper.sv
id_mapper_sva.sv
tb_id_mapper.sv
